/* filelist.f */
common/rgbd_vo_pkg.sv
design/frame_end_join.sv
design/normal_eq_accum.sv
design/normal_eq_merge.sv
testbench/tb_clock_gen.sv
testbench/tb_normal_eq_merge.sv

/* run_sim.sh */
#!/bin/sh
# Builds the normal-equation merge testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.

ROOT_DIR=$(cd "$(dirname "$0")" && pwd)
if [ $? -ne 0 ]; then
    echo "Cannot resolve the project directory"
    exit 1
fi

cd "$ROOT_DIR"
if [ $? -ne 0 ]; then
    echo "Cannot enter $ROOT_DIR"
    exit 1
fi

TOP=tb_normal_eq_merge
BUILD_DIR=obj_dir
LOG_FILE=sim.log

command -v verilator > /dev/null 2>&1
if [ $? -ne 0 ]; then
    echo "verilator is not on the PATH"
    exit 1
fi

# Build
verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -f filelist.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

# Run
"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
    echo "Simulation executable returned status $status"
fi

# Verdict comes from the log
grep -q "^Simulation passed$" "$LOG_FILE"
if [ $? -eq 0 ] && [ $status -eq 0 ]; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

/* testbench/tb_normal_eq_merge.sv */
// Testbench for the normal-equation merge.
// Applies a table of frame scenarios, drives random terms from an LFSR and
// checks o_frame_end and o_sum against a reference model every cycle.

`timescale 1ns/1ns

module tb_normal_eq_merge
    import rgbd_vo_pkg::*;
();

    //============================================================
    // Scenario table
    //============================================================
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int ROW_CYCLES   = 6;
    localparam int NUM_ROWS     = 12;
    localparam int NUM_COLS     = 4;

    localparam int COL_FS     = 0;
    localparam int COL_ICP    = 1;
    localparam int COL_RGBD   = 2;
    localparam int COL_PULSES = 3;

    // Columns: frame start, ICP offset, RGBD offset, expected pulses
    // Offset -1 means the path stays quiet in that row
    localparam int SCENARIOS [NUM_ROWS][NUM_COLS] = '{
        '{0, -1, -1, 0},
        '{1,  1,  3, 1},
        '{1,  3,  1, 1},
        '{1,  2,  4, 1},
        '{1,  2,  2, 0},
        '{0, -1,  3, 1},
        '{0,  1,  2, 1},
        '{0,  4,  2, 1},
        '{0,  1,  1, 0},
        '{0, -1,  1, 1},
        '{1, -1, -1, 0},
        '{0,  3,  1, 1}
    };

    localparam int TIMEOUT_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_CYCLES + 50;

    // Model join states
    localparam int S_IDLE      = 0;
    localparam int S_WAIT_RGBD = 1;
    localparam int S_WAIT_ICP  = 2;
    localparam int S_DONE      = 3;

    //============================================================
    // Signals
    //============================================================
    logic       clk;
    logic       rst_n;
    logic       frame_start;
    logic       icp_end;
    normal_eq_t icp_eq;
    logic       rgbd_end;
    normal_eq_t rgbd_eq;
    normal_eq_t o_sum;
    logic       o_frame_end;

    logic [15:0] lfsr_q = 16'd35755;
    normal_eq_t  exp_sum;
    int          exp_state;
    logic        exp_frame_end;
    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;

    tb_clock_gen #(
         .CLK_PERIOD   (CLK_PERIOD)
        ,.RESET_CYCLES (RESET_CYCLES)
    ) tb_clock_gen_i (
         .o_clk   (clk)
        ,.o_rst_n (rst_n)
    );

    normal_eq_merge normal_eq_merge_i (
         .i_clk         (clk)
        ,.i_rst_n       (rst_n)
        ,.i_frame_start (frame_start)
        ,.i_icp_end     (icp_end)
        ,.i_icp_eq      (icp_eq)
        ,.i_rgbd_end    (rgbd_end)
        ,.i_rgbd_eq     (rgbd_eq)
        ,.o_sum         (o_sum)
        ,.o_frame_end   (o_frame_end)
    );

    //============================================================
    // Random terms
    //============================================================

    // Galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            lfsr_next = (s >> 1) ^ 16'hB400;
        end else begin
            lfsr_next = s >> 1;
        end
    endfunction

    task automatic random_term(output term_t t);
        t = '0;
        for (int b = 0; b < TERM_BW; b++) begin
            lfsr_q = lfsr_next(lfsr_q);
            t = {t[TERM_BW-2:0], lfsr_q[0]};
        end
    endtask

    task automatic random_eq(output normal_eq_t eq);
        term_t t;
        for (int i = 0; i < NUM_MAT_TERMS; i++) begin
            random_term(t);
            eq.mat[i] = t;
        end
        for (int i = 0; i < NUM_VEC_TERMS; i++) begin
            random_term(t);
            eq.vec[i] = t;
        end
    endtask

    //============================================================
    // Reference model
    //============================================================
    task automatic add_to_model(input normal_eq_t eq);
        for (int i = 0; i < NUM_MAT_TERMS; i++) begin
            exp_sum.mat[i] = exp_sum.mat[i] + eq.mat[i];
        end
        for (int i = 0; i < NUM_VEC_TERMS; i++) begin
            exp_sum.vec[i] = exp_sum.vec[i] + eq.vec[i];
        end
    endtask

    task automatic step_model(input bit fs, input bit icp, input bit rgbd,
                              input normal_eq_t icp_val, input normal_eq_t rgbd_val);
        // Clear first, then ICP before RGBD
        if (fs) begin
            exp_sum = '0;
        end else if (icp) begin
            add_to_model(icp_val);
        end else if (rgbd) begin
            add_to_model(rgbd_val);
        end
        case (exp_state)
            S_IDLE: begin
                if (icp) begin
                    exp_state = S_WAIT_RGBD;
                end else if (rgbd) begin
                    exp_state = S_WAIT_ICP;
                end
            end
            S_WAIT_RGBD: begin
                if (rgbd) begin
                    exp_state = S_DONE;
                end
            end
            S_WAIT_ICP: begin
                if (icp) begin
                    exp_state = S_DONE;
                end
            end
            default: begin
                exp_state = S_IDLE;
            end
        endcase
        exp_frame_end = (exp_state == S_DONE);
    endtask

    //============================================================
    // Checks
    //============================================================
    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("Error: %s = 0x%h, expected 0x%h at %0t", name, actual, expected,
                     $time);
        end
    endtask

    task automatic check_sums();
        for (int i = 0; i < NUM_MAT_TERMS; i++) begin
            check_value($sformatf("o_sum.mat[%0d]", i), o_sum.mat[i], exp_sum.mat[i]);
        end
        for (int i = 0; i < NUM_VEC_TERMS; i++) begin
            check_value($sformatf("o_sum.vec[%0d]", i), o_sum.vec[i], exp_sum.vec[i]);
        end
    endtask

    // Fresh random data on both buses every cycle, strobed or not
    task automatic apply_cycle(input bit fs, input bit icp, input bit rgbd);
        normal_eq_t icp_val;
        normal_eq_t rgbd_val;
        random_eq(icp_val);
        random_eq(rgbd_val);
        frame_start = fs;
        icp_end     = icp;
        rgbd_end    = rgbd;
        icp_eq      = icp_val;
        rgbd_eq     = rgbd_val;
        step_model(fs, icp, rgbd, icp_val, rgbd_val);
    endtask

    //============================================================
    // Main sequence
    //============================================================
    initial begin : main
        int row_pulses;
        frame_start   = 1'b0;
        icp_end       = 1'b0;
        rgbd_end      = 1'b0;
        icp_eq        = '0;
        rgbd_eq       = '0;
        exp_sum       = '0;
        exp_state     = S_IDLE;
        exp_frame_end = 1'b0;

        @(posedge rst_n);

        for (int r = 0; r < NUM_ROWS; r++) begin
            row_pulses = 0;
            for (int k = 0; k < ROW_CYCLES; k++) begin
                @(posedge clk);
                #1;
                // Outputs here reflect the inputs of the previous cycle
                check_value("o_frame_end", 64'(o_frame_end), 64'(exp_frame_end));
                if (o_frame_end) begin
                    row_pulses++;
                end
                if (exp_frame_end || k == ROW_CYCLES - 1) begin
                    check_sums();
                end
                apply_cycle(SCENARIOS[r][COL_FS] != 0 && k == 0,
                            SCENARIOS[r][COL_ICP] == k,
                            SCENARIOS[r][COL_RGBD] == k);
            end
            check_value($sformatf("o_frame_end pulses in row %0d", r),
                        64'(row_pulses), 64'(SCENARIOS[r][COL_PULSES]));
        end

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation failed");
            $finish;
        end
    end

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock and reset source.
// Free-running clock, active-low reset released after RESET_CYCLES edges.

`timescale 1ns/1ns

module tb_clock_gen #(
     parameter int CLK_PERIOD   = 8
    ,parameter int RESET_CYCLES = 16
) (
     output logic o_clk
    ,output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) o_clk = ~o_clk;
        end
    end

    // Release just after an edge so no flop sees it change at the edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

/* design/normal_eq_merge.sv */
// Merges the ICP and photometric partial normal equations of one frame.
// o_sum holds the running sum of the reported equations, and o_frame_end
// pulses once both paths have delivered their frame-end strobe.
// Strobes are consumed in the cycle they are seen; there is no back-pressure.

`timescale 1ns/1ns

module normal_eq_merge
    import rgbd_vo_pkg::*;
(
    // Control
     input  logic       i_clk
    ,input  logic       i_rst_n
    ,input  logic       i_frame_start
    // Geometric path
    ,input  logic       i_icp_end
    ,input  normal_eq_t i_icp_eq
    // Photometric path
    ,input  logic       i_rgbd_end
    ,input  normal_eq_t i_rgbd_eq
    // Merged result
    ,output normal_eq_t o_sum
    ,output logic       o_frame_end
);

    //==========================================================
    // Frame-end join
    //==========================================================

    // Both strobes go to the join and to the accumulator
    frame_end_join frame_end_join_i (
         .i_clk       (i_clk)
        ,.i_rst_n     (i_rst_n)
        ,.i_icp_end   (i_icp_end)
        ,.i_rgbd_end  (i_rgbd_end)
        ,.o_frame_end (o_frame_end)
    );

    //==========================================================
    // Normal-equation sums
    //==========================================================

    // Sum already includes the second strobe when the pulse is high
    normal_eq_accum normal_eq_accum_i (
         .i_clk         (i_clk)
        ,.i_rst_n       (i_rst_n)
        ,.i_frame_start (i_frame_start)
        ,.i_icp_end     (i_icp_end)
        ,.i_icp_eq      (i_icp_eq)
        ,.i_rgbd_end    (i_rgbd_end)
        ,.i_rgbd_eq     (i_rgbd_eq)
        ,.o_sum         (o_sum)
    );

endmodule

/* design/normal_eq_accum.sv */
// Running sums of the ICP and photometric normal equations of one frame.
// Frame start clears all terms; a path strobe adds that path's terms.
// When both strobes arrive together only the ICP terms are added.

`timescale 1ns/1ns

module normal_eq_accum
    import rgbd_vo_pkg::*;
(
     input  logic       i_clk
    ,input  logic       i_rst_n
    ,input  logic       i_frame_start
    ,input  logic       i_icp_end
    ,input  normal_eq_t i_icp_eq
    ,input  logic       i_rgbd_end
    ,input  normal_eq_t i_rgbd_eq
    ,output normal_eq_t o_sum
);

    //==========================================================
    // Signals
    //==========================================================

    // Addend chosen from the reporting path
    normal_eq_t                addend;
    logic                      add_en;

    // Flat views of the payload, one entry per term
    term_t [NUM_TERMS-1:0]     addend_terms;
    term_t [NUM_TERMS-1:0]     sum_terms;

    // Running sums, one register per term
    term_t                     sum_q [NUM_TERMS];

    //==========================================================
    // Addend select
    //==========================================================

    // ICP has priority; the photometric terms of a shared cycle are dropped
    always_comb begin
        if (i_icp_end) begin
            addend = i_icp_eq;
        end else begin
            addend = i_rgbd_eq;
        end
    end

    assign add_en = i_icp_end | i_rgbd_end;

    // Same bit layout, vec in the low terms and mat above it
    assign addend_terms = addend;

    //==========================================================
    // Term accumulators
    //==========================================================
    for (genvar gi = 0; gi < NUM_TERMS; gi++) begin : g_term
        always_ff @(posedge i_clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                sum_q[gi] <= '0;
            end else if (i_frame_start) begin
                // Clear overrides both strobes
                sum_q[gi] <= '0;
            end else if (add_en) begin
                // Wraps modulo 2^64
                sum_q[gi] <= sum_q[gi] + addend_terms[gi];
            end
        end
    end

    //==========================================================
    // Output
    //==========================================================
    always_comb begin
        for (int k = 0; k < NUM_TERMS; k++) begin
            sum_terms[k] = sum_q[k];
        end
    end

    assign o_sum = sum_terms;

    //==========================================================
    // Assertions
    //==========================================================

    // Every sum register holds a known value once out of reset
    a_sum_known: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !$isunknown(o_sum)
    ) else $error("unknown bits in running sum");

endmodule

/* design/frame_end_join.sv */
// Joins the ICP and photometric frame-end strobes into one frame-end pulse.
// The pulse is high for one cycle after both paths have reported.
// Frame start does not touch this machine; only reset returns it to IDLE.

`timescale 1ns/1ns

module frame_end_join
    import rgbd_vo_pkg::*;
(
     input  logic i_clk
    ,input  logic i_rst_n
    ,input  logic i_icp_end
    ,input  logic i_rgbd_end
    ,output logic o_frame_end
);

    //==========================================================
    // Signals
    //==========================================================
    join_state_t state_q;
    join_state_t state_d;

    //==========================================================
    // Next state
    //==========================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                // ICP wins when both strobes land together
                if (i_icp_end) begin
                    state_d = WAIT_RGBD;
                end else if (i_rgbd_end) begin
                    state_d = WAIT_ICP;
                end
            end
            WAIT_RGBD: begin
                if (i_rgbd_end) begin
                    state_d = DONE;
                end
            end
            WAIT_ICP: begin
                if (i_icp_end) begin
                    state_d = DONE;
                end
            end
            DONE: begin
                // Strobes seen here are summed but not joined
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    //==========================================================
    // State register
    //==========================================================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Pulse decoded straight from the state
    assign o_frame_end = (state_q == DONE);

    //==========================================================
    // Assertions
    //==========================================================

    // DONE lasts exactly one cycle
    a_single_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_frame_end |=> !o_frame_end
    ) else $error("frame end pulse longer than one cycle");

    // Pulse only after waiting on the second path
    a_pulse_after_wait: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_frame_end) |-> ($past(state_q) inside {WAIT_RGBD, WAIT_ICP})
    ) else $error("frame end pulse without a wait state before it");

endmodule

/* common/rgbd_vo_pkg.sv */
// Shared types for the RGB-D visual odometry normal-equation merge.
// Defines the term width, the stored term counts, the packed
// normal-equation payload and the frame-end join state encoding.

package rgbd_vo_pkg;

    //==========================================================
    // Term sizes
    //==========================================================

    // Width of one matrix or vector term
    localparam int TERM_BW = 64;

    // Lower triangle of the symmetric 6x6 matrix
    localparam int NUM_MAT_TERMS = 21;

    // Right-hand side vector
    localparam int NUM_VEC_TERMS = 6;

    // All terms of one normal equation, matrix and vector together
    localparam int NUM_TERMS = NUM_MAT_TERMS + NUM_VEC_TERMS;

    //==========================================================
    // Payload types
    //==========================================================

    // One term, summed modulo 2^64 with no sign handling
    typedef logic [TERM_BW-1:0] term_t;

    // Matrix terms are stored column by column, lower triangle only:
    //   mat[0..5]   = 00 10 20 30 40 50
    //   mat[6..10]  = 11 21 31 41 51
    //   mat[11..14] = 22 32 42 52
    //   mat[15..17] = 33 43 53
    //   mat[18..19] = 44 54
    //   mat[20]     = 55
    // vec[k] is the k-th term of the vector
    typedef struct packed {
        term_t [NUM_MAT_TERMS-1:0] mat;
        term_t [NUM_VEC_TERMS-1:0] vec;
    } normal_eq_t;

    //==========================================================
    // Join state machine
    //==========================================================

    // IDLE      no path has reported in this frame
    // WAIT_RGBD ICP reported, photometric path still missing
    // WAIT_ICP  photometric path reported, ICP still missing
    // DONE      both reported, frame-end pulse cycle
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        WAIT_RGBD = 2'd1,
        WAIT_ICP  = 2'd2,
        DONE      = 2'd3
    } join_state_t;

endpackage
